// ==== obj_line.f ====
+incdir+.
obj_line_pkg.sv
obj_dpram.sv
obj_apb_regs.sv
obj_slot_cnt.sv
obj_tile_expand.sv
obj_line_fsm.sv
obj_line_top.sv
obj_line_checker.sv
obj_line_assert.sv
obj_line_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the obj_line testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f obj_line.f --top-module obj_line_tb \
    -o obj_line_sim && ./obj_dir/obj_line_sim | tee sim.log || exit 1

grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== obj_line_tb.sv ====
`timescale 1ns/1ps
`include "obj_line_cfg.svh"

module obj_line_tb;

    localparam int num_tests = 9;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [12:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        done;
    logic [8:0]  line_addr;
    logic [15:0] line_data;
    logic [15:0] tbl [`OBJ_TABLE_WORDS];  // host copy of the object table
    logic [15:0] exp_words [384];
    logic        chk_start;
    logic [8:0]  rnd_line;
    int          test_id;
    int          sweeps;
    int          chk_errors;
    int          tb_errors;
    int          done_cnt = 0;

    obj_line_top dut (.*);

    obj_line_checker u_chk (
        .clk      (clk),
        .start    (chk_start),
        .test_id  (test_id),
        .exp_words(exp_words),
        .line_data(line_data),
        .line_addr(line_addr),
        .sweeps   (sweeps),
        .errors   (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) if (done) done_cnt++;

    // table load plus two builds and a sweep for each test
    initial begin
        #(num_tests * (4 * 1024 + 3 * 2048) * 4 + 2000);
        $display("timeout: the builds did not finish in the expected time");
        $display("Test failed");
        $finish;
    end

    task automatic apb_write(input logic [12:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        #1 err = pslverr;
        if (!pready) begin
            tb_errors++;
            $display("mismatch at %0t: pready low in a write access phase", $time);
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [12:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        psel  = 1'b1;
        paddr = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        #1 data = prdata;
        if (!pready) begin
            tb_errors++;
            $display("mismatch at %0t: pready low in a read access phase", $time);
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_obj(input int k, input logic [15:0] a, input logic [15:0] c,
                           input logic [15:0] y, input logic [15:0] x);
        tbl[4*k]   = a;
        tbl[4*k+1] = c;
        tbl[4*k+2] = y;
        tbl[4*k+3] = x;
    endtask

    // identical objects 256 lines away from the line
    task automatic fill_empty(input logic [8:0] line);
        for (int k = 0; k < 256; k++) set_obj(k, 16'd0, 16'd0, 16'((line + 256) % 512), 16'd0);
    endtask

    task automatic random_table(input logic [8:0] line);
        logic [15:0] a;
        for (int k = 0; k < 256; k++) begin
            if (k > 0 && $urandom_range(7) == 0) begin
                set_obj(k, tbl[4*k-4], tbl[4*k-3], tbl[4*k-2], tbl[4*k-1]);  // repeat
            end else begin
                a = 16'($urandom);
                a[15:14] = 2'd0;                  // at most 4 rows and 4 columns
                a[11:10] = 2'd0;
                set_obj(k, a, 16'($urandom), 16'((int'(line) + 512 - $urandom_range(511)) % 512),
                        16'($urandom_range(511)));
            end
        end
    endtask

    task automatic load_table();
        logic err;
        for (int i = 0; i < `OBJ_TABLE_WORDS; i++) apb_write(13'(i * 4), {16'd0, tbl[i]}, err);
    endtask

    // expected words 0..2 of every slot for one line
    function automatic void build_ref(input logic [8:0] line, input logic [3:0] boff,
                                      input logic [3:0] bmask);
        logic [15:0] a;
        logic [15:0] c;
        logic [15:0] y;
        logic [15:0] x;
        logic [15:0] code;
        logic [15:0] ex;
        logic [8:0]  dy;
        logic [3:0]  msel;
        logic [3:0]  npos;
        logic [3:0]  vs;
        int          s;
        bit          stop;
        bit          rep;
        s    = 0;
        stop = 0;
        for (int k = 255; k >= 0 && !stop; k--) begin
            a   = tbl[4*k];
            c   = tbl[4*k+1];
            y   = tbl[4*k+2];
            x   = tbl[4*k+3];
            rep = k < 255 && a == tbl[4*k+4] && c == tbl[4*k+5] && y == tbl[4*k+6] &&
                  x == tbl[4*k+7];
            dy  = line - y[8:0];
            if ((c[15:12] & ~bmask) == 4'd0 && !rep && dy[8:4] <= {1'b0, a[15:12]}) begin
                code = {(c[15:12] & bmask) | boff, c[11:0]};
                msel = a[6] ? a[15:12] - dy[7:4] : dy[7:4];   // vflip
                vs   = dy[3:0] ^ {4{a[6]}};
                for (int n = 0; n <= int'(a[11:8]) && !stop; n++) begin
                    npos = a[5] ? a[11:8] - 4'(n) : 4'(n);    // hflip
                    ex   = {7'd0, x[8:0]} + {8'd0, npos, 4'd0};
                    exp_words[3*s]   = {4'd0, vs, a[7:0]};
                    exp_words[3*s+1] = {code[15:8], code[7:4] + msel, code[3:0] + 4'(n)};
                    exp_words[3*s+2] = ex;
                    if (s == `LINE_SLOTS - 1) stop = 1;
                    else if (int'(ex) > `X_MIN && int'(ex) < `X_MAX) s++;
                end
            end
        end
        for (int f = s; f < `LINE_SLOTS && !stop; f++) begin
            exp_words[3*f]   = '1;
            exp_words[3*f+1] = '1;
            exp_words[3*f+2] = '1;
        end
    endfunction

    task automatic run_test(input logic [8:0] line, input logic [3:0] boff,
                            input logic [3:0] bmask, input bit try_busy);
        logic        err;
        logic [31:0] rd;
        int          n;
        test_id++;
        load_table();
        apb_write(`APB_BANK, {24'd0, bmask, boff}, err);
        build_ref(line, boff, bmask);
        n = done_cnt;
        apb_write(`APB_CMD, {23'd0, line}, err);
        if (err) begin
            tb_errors++;
            $display("mismatch at %0t: test %0d build command got pslverr", $time, test_id);
        end
        wait (done_cnt == n + 1);
        apb_read(`APB_STATUS, rd);
        if (rd[1:0] != 2'b10) begin
            tb_errors++;
            $display("mismatch at %0t: test %0d status after the build did not show done",
                     $time, test_id);
        end
        apb_read(`APB_STATUS, rd);
        if (rd[1]) begin
            tb_errors++;
            $display("mismatch at %0t: test %0d status read did not clear done",
                     $time, test_id);
        end
        // build the other bank so the finished one is on the read port
        apb_write(`APB_CMD, {23'd0, line ^ 9'd1}, err);
        @(posedge clk);
        #1 chk_start = 1'b1;
        @(posedge clk);
        #1 chk_start = 1'b0;
        if (try_busy) begin
            apb_write(`APB_CMD, {23'd0, line}, err);
            if (!err) begin
                tb_errors++;
                $display("mismatch at %0t: test %0d command during a build got no pslverr",
                         $time, test_id);
            end
        end
        wait (sweeps == test_id && done_cnt == n + 2);
    endtask

    initial begin
        void'($urandom(28996));
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        chk_start = 1'b0;
        test_id   = 0;
        tb_errors = 0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        fill_empty(9'd100);                   // nothing on screen
        run_test(9'd100, 4'd0, 4'hf, 1'b0);

        fill_empty(9'd100);
        set_obj(10, 16'h0012, 16'h0120, 16'd90, 16'd100);
        set_obj(9, 16'h2325, 16'h0340, 16'd80, 16'd60);
        set_obj(8, 16'h1141, 16'h0fe8, 16'd95, 16'd200);
        set_obj(7, 16'h3263, 16'h0abc, 16'd70, 16'd300);
        run_test(9'd100, 4'd0, 4'hf, 1'b0);

        fill_empty(9'd201);
        set_obj(20, 16'h0101, 16'h2345, 16'd200, 16'd120);
        set_obj(19, 16'h0101, 16'h2345, 16'd200, 16'd120);
        set_obj(18, 16'h0002, 16'hc123, 16'd200, 16'd150);
        set_obj(17, 16'h0003, 16'h1777, 16'd200, 16'd10);
        set_obj(16, 16'h0004, 16'h0888, 16'd200, 16'd400);
        run_test(9'd201, 4'h4, 4'h3, 1'b0);

        fill_empty(9'd50);                    // 160 tiles is more than a line holds
        for (int k = 0; k < 40; k++) set_obj(k + 100, 16'h0300 | 16'(k), 16'(k * 16), 16'd45,
                                             16'd100);
        run_test(9'd50, 4'd0, 4'hf, 1'b0);

        rnd_line = 9'($urandom_range(511));
        random_table(rnd_line);
        run_test(rnd_line, 4'd0, 4'hf, 1'b1);

        for (int i = 0; i < 4; i++) begin
            rnd_line = 9'($urandom_range(511));
            random_table(rnd_line);
            run_test(rnd_line, 4'($urandom), 4'($urandom), 1'b0);
        end

        $display("%0d tests run, %0d word mismatches, %0d other errors",
                 test_id, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== obj_line_assert.sv ====
`timescale 1ns/1ps

module obj_line_assert (
    input logic                     clk,
    input logic                     rst,
    input obj_line_pkg::fsm_state_t state,
    input logic                     done,
    input logic                     busy,
    input logic                     lbuf_we,
    input logic [6:0]               slot
);
    import obj_line_pkg::*;

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_we_busy: assert property (@(posedge clk) disable iff (rst) !busy |-> !lbuf_we)
        else $error("line buffer written while the builder is idle");

    // the last slot holds until the next build clears the counter
    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
                                slot == 7'd127 && state != ST_IDLE |=> slot == 7'd127)
        else $error("slot counter wrapped past 127");

endmodule

bind obj_line_fsm obj_line_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .state   (state),
    .done    (done),
    .busy    (busy),
    .lbuf_we (lbuf_we),
    .slot    (slot)
);

// ==== obj_line_checker.sv ====
`timescale 1ns/1ps

module obj_line_checker (
    input  logic        clk,
    input  logic        start,
    input  int          test_id,
    input  logic [15:0] exp_words [384],
    input  logic [15:0] line_data,
    output logic [8:0]  line_addr,
    output int          sweeps,
    output int          errors
);

    // one sweep per start pulse, slots 0..127 and words 0..2
    initial begin
        int bad;
        line_addr = '0;
        sweeps    = 0;
        errors    = 0;
        forever begin
            @(posedge clk);
            if (start) begin
                bad = 0;
                #1;
                for (int a = 0; a < 384; a++) begin
                    line_addr = {7'(a / 3), 2'(a % 3)};
                    @(posedge clk);
                    #1;                           // read data registered at that edge
                    if (line_data !== exp_words[a]) begin
                        $display("mismatch at %0t: test %0d slot %0d word %0d got %h expected %h",
                                 $time, test_id, a / 3, a % 3, line_data, exp_words[a]);
                        bad++;
                    end
                end
                errors += bad;
                sweeps++;
                $display("test %0d finished, %0d of 384 words wrong", test_id, bad);
            end
        end
    end

endmodule

// ==== obj_line_top.sv ====
`timescale 1ns/1ps
`include "obj_line_cfg.svh"

module obj_line_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [12:0]              paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic [8:0]               line_addr,
    output obj_line_pkg::line_word_t line_data,
    output logic                     done
);
    import obj_line_pkg::*;

    logic       table_we;
    logic [9:0] table_waddr;
    obj_word_t  table_wdata;
    logic [9:0] table_raddr;
    obj_word_t  table_rdata;
    logic [3:0] bank_offset;
    logic [3:0] bank_mask;
    logic       build;
    logic [8:0] build_line;
    logic       busy;
    logic       inzone;
    logic [3:0] vsub;
    line_word_t code_mn;
    line_word_t eff_x;
    logic [6:0] slot;
    logic       slot_full;
    logic [3:0] tile_n_idx;
    logic [3:0] npos;
    logic       cnt_clear;
    logic       slot_inc;
    logic       tile_load;
    logic       tile_inc;
    obj_word_t  obj_attr;
    obj_word_t  obj_code;
    obj_word_t  obj_y;
    obj_word_t  obj_x;
    logic [8:0] line_q;
    logic       lbuf_we;
    logic [9:0] lbuf_waddr;
    line_word_t lbuf_wdata;
    line_word_t lbuf_rdata;
    logic       rd_ok;

    obj_apb_regs u_apb (.*);

    obj_line_fsm u_fsm (.*);

    obj_slot_cnt u_cnt (
        .clk       (clk),
        .rst       (rst),
        .cnt_clear (cnt_clear),
        .slot_inc  (slot_inc),
        .tile_load (tile_load),
        .tile_inc  (tile_inc),
        .hflip     (obj_attr[5]),
        .tile_n    (obj_attr[11:8]),
        .slot      (slot),
        .slot_full (slot_full),
        .tile_n_idx(tile_n_idx),
        .npos      (npos)
    );

    obj_tile_expand u_expand (
        .line_q  (line_q),
        .obj_attr(obj_attr),
        .obj_code(obj_code),
        .obj_y   (obj_y),
        .obj_x   (obj_x),
        .n       (tile_n_idx),
        .npos    (npos),
        .inzone  (inzone),
        .vsub    (vsub),
        .code_mn (code_mn),
        .eff_x   (eff_x)
    );

    obj_dpram #(.payload_t(obj_word_t), .depth(`OBJ_TABLE_WORDS)) u_table (
        .clk  (clk),
        .we   (table_we),
        .waddr(table_waddr),
        .wdata(table_wdata),
        .raddr(table_raddr),
        .rdata(table_rdata)
    );

    // renderer reads the bank that is not being built
    obj_dpram #(.payload_t(line_word_t), .depth(`LINE_WORDS)) u_lbuf (
        .clk  (clk),
        .we   (lbuf_we),
        .waddr(lbuf_waddr),
        .wdata(lbuf_wdata),
        .raddr({~line_q[0], line_addr}),
        .rdata(lbuf_rdata)
    );

    // line_data stays zero until the first read after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) rd_ok <= 1'b0;
        else     rd_ok <= 1'b1;
    end

    assign line_data = rd_ok ? lbuf_rdata : '0;

endmodule

// ==== obj_line_fsm.sv ====
`timescale 1ns/1ps
`include "obj_line_cfg.svh"

module obj_line_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     build,
    input  logic [8:0]               build_line,
    input  logic [3:0]               bank_offset,
    input  logic [3:0]               bank_mask,
    output logic [9:0]               table_raddr,
    input  obj_line_pkg::obj_word_t  table_rdata,
    input  logic                     inzone,
    input  logic [3:0]               vsub,
    input  obj_line_pkg::line_word_t code_mn,
    input  obj_line_pkg::line_word_t eff_x,
    input  logic [6:0]               slot,
    input  logic                     slot_full,
    input  logic [3:0]               tile_n_idx,
    output logic                     cnt_clear,
    output logic                     slot_inc,
    output logic                     tile_load,
    output logic                     tile_inc,
    output obj_line_pkg::obj_word_t  obj_attr,
    output obj_line_pkg::obj_word_t  obj_code,
    output obj_line_pkg::obj_word_t  obj_y,
    output obj_line_pkg::obj_word_t  obj_x,
    output logic [8:0]               line_q,
    output logic                     lbuf_we,
    output logic [9:0]               lbuf_waddr,
    output obj_line_pkg::line_word_t lbuf_wdata,
    output logic                     busy,
    output logic                     done
);
    import obj_line_pkg::*;

    fsm_state_t state;
    obj_word_t  raw_code;
    obj_word_t  last_attr;
    obj_word_t  last_code;
    obj_word_t  last_y;
    obj_word_t  last_x;
    logic       first;
    logic       repeated;
    logic       visible;
    logic       next_obj;
    logic       in_window;
    logic       last_tile;
    logic [1:0] word_idx;

    // bank offset replaces the masked-out part of the upper nibble
    assign obj_code  = {(raw_code[15:12] & bank_mask) | bank_offset, raw_code[11:0]};
    assign repeated  = !first && obj_attr == last_attr && raw_code == last_code &&
                       obj_y == last_y && obj_x == last_x;
    assign visible   = inzone && !repeated;
    assign in_window = eff_x > `X_MIN && eff_x < `X_MAX;
    assign last_tile = tile_n_idx == obj_attr[11:8];
    assign next_obj  = (state == ST_CHK_MAP && (raw_code[15:12] & ~bank_mask) != 4'd0) ||
                       (state == ST_CHK_VIS && !visible) ||
                       (state == ST_ADV && !slot_full && last_tile);

    assign cnt_clear = state == ST_IDLE && build;
    assign tile_load = state == ST_CHK_VIS && visible;
    assign tile_inc  = state == ST_ADV && !slot_full && !last_tile;
    assign slot_inc  = !slot_full && ((state == ST_ADV && in_window) || state == ST_FILL2);

    always_comb begin
        lbuf_we    = 1'b1;
        word_idx   = 2'd0;
        lbuf_wdata = '1;                      // fill pattern
        case (state)
            ST_WR0:   lbuf_wdata = {4'd0, vsub, obj_attr[7:0]};
            ST_WR1: begin
                word_idx   = 2'd1;
                lbuf_wdata = code_mn;
            end
            ST_WR2: begin
                word_idx   = 2'd2;
                lbuf_wdata = eff_x;
            end
            ST_FILL0: word_idx = 2'd0;
            ST_FILL1: word_idx = 2'd1;
            ST_FILL2: word_idx = 2'd2;
            default:  lbuf_we = 1'b0;
        endcase
    end

    assign lbuf_waddr = {line_q[0], slot, word_idx};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ST_IDLE;
            busy        <= 1'b0;
            done        <= 1'b0;
            first       <= 1'b1;
            table_raddr <= 10'd0;
            line_q      <= 9'd0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: if (build) begin
                    line_q      <= build_line;
                    table_raddr <= 10'(`OBJ_TABLE_WORDS - 4);  // attr of the top object
                    first       <= 1'b1;
                    busy        <= 1'b1;
                    state       <= ST_RD_ATTR;
                end
                ST_RD_ATTR: begin
                    table_raddr <= table_raddr + 10'd1;
                    state       <= ST_RD_CODE;
                end
                ST_RD_CODE: begin
                    last_attr   <= obj_attr;
                    obj_attr    <= table_rdata;
                    table_raddr <= table_raddr + 10'd1;
                    state       <= ST_RD_Y;
                end
                ST_RD_Y: begin
                    last_code   <= raw_code;
                    raw_code    <= table_rdata;
                    table_raddr <= table_raddr + 10'd1;
                    state       <= ST_RD_X;
                end
                ST_RD_X: begin
                    last_y <= obj_y;
                    obj_y  <= table_rdata;
                    state  <= ST_CHK_MAP;
                end
                ST_CHK_MAP: begin
                    last_x <= obj_x;
                    obj_x  <= table_rdata;
                    state  <= ST_CHK_VIS;
                end
                ST_CHK_VIS: begin
                    first <= 1'b0;
                    state <= ST_WR0;
                end
                ST_WR0:   state <= ST_WR1;
                ST_WR1:   state <= ST_WR2;
                ST_WR2:   state <= ST_ADV;
                ST_FILL0: state <= ST_FILL1;
                ST_FILL1: state <= ST_FILL2;
                ST_ADV, ST_FILL2: begin
                    if (slot_full) begin          // slot 127 written, line is complete
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= ST_IDLE;
                    end else begin
                        state <= state == ST_ADV ? ST_WR0 : ST_FILL0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (next_obj) begin
                first <= 1'b0;
                if (table_raddr[9:2] == 8'd0) begin
                    state <= ST_FILL0;            // object 0 done
                end else begin
                    table_raddr <= {table_raddr[9:2] - 8'd1, 2'd0};
                    state       <= ST_RD_ATTR;
                end
            end
        end
    end

endmodule

// ==== obj_tile_expand.sv ====
`timescale 1ns/1ps

module obj_tile_expand (
    input  logic [8:0]               line_q,
    input  obj_line_pkg::obj_word_t  obj_attr,
    input  obj_line_pkg::obj_word_t  obj_code,
    input  obj_line_pkg::obj_word_t  obj_y,
    input  obj_line_pkg::obj_word_t  obj_x,
    input  logic [3:0]               n,
    input  logic [3:0]               npos,
    output logic                     inzone,
    output logic [3:0]               vsub,
    output obj_line_pkg::line_word_t code_mn,
    output obj_line_pkg::line_word_t eff_x
);

    logic [3:0] tile_m;
    logic       vflip;
    logic [8:0] dy;
    logic [3:0] m_row;
    logic [3:0] m_sel;

    assign tile_m = obj_attr[15:12];          // tiles high, minus one
    assign vflip  = obj_attr[6];

    // distance below the sprite top, wraps at 512 lines
    assign dy     = line_q - obj_y[8:0];
    assign inzone = dy[8:4] <= {1'b0, tile_m};

    assign m_row = dy[7:4];                   // matched tile row
    assign m_sel = vflip ? tile_m - m_row : m_row;

    // row goes into bits 7..4, column into bits 3..0, each wraps on its own
    assign code_mn = {obj_code[15:8], obj_code[7:4] + m_sel, obj_code[3:0] + n};

    assign vsub = dy[3:0] ^ {4{vflip}};

    assign eff_x = {7'd0, obj_x[8:0]} + {8'd0, npos, 4'd0};

endmodule

// ==== obj_slot_cnt.sv ====
`timescale 1ns/1ps
`include "obj_line_cfg.svh"

module obj_slot_cnt (
    input  logic       clk,
    input  logic       rst,
    input  logic       cnt_clear,
    input  logic       slot_inc,
    input  logic       tile_load,
    input  logic       tile_inc,
    input  logic       hflip,
    input  logic [3:0] tile_n,
    output logic [6:0] slot,
    output logic       slot_full,
    output logic [3:0] tile_n_idx,
    output logic [3:0] npos
);

    assign slot_full = slot == 7'(`LINE_SLOTS - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot <= 7'd0;
        end else if (cnt_clear) begin
            slot <= 7'd0;
        end else if (slot_inc) begin
            slot <= slot + 7'd1;
        end
    end

    // n counts tiles from the left edge, npos is the x tile position on screen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_n_idx <= 4'd0;
            npos       <= 4'd0;
        end else if (cnt_clear) begin
            tile_n_idx <= 4'd0;
            npos       <= 4'd0;
        end else if (tile_load) begin
            tile_n_idx <= 4'd0;
            npos       <= hflip ? tile_n : 4'd0;   // flipped sprites start from the right
        end else if (tile_inc) begin
            tile_n_idx <= tile_n_idx + 4'd1;
            npos       <= hflip ? npos - 4'd1 : npos + 4'd1;
        end
    end

endmodule

// ==== obj_apb_regs.sv ====
`timescale 1ns/1ps
`include "obj_line_cfg.svh"

module obj_apb_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [12:0]             paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    busy,
    input  logic                    done,
    output logic                    table_we,
    output logic [9:0]              table_waddr,
    output obj_line_pkg::obj_word_t table_wdata,
    output logic [3:0]              bank_offset,
    output logic [3:0]              bank_mask,
    output logic                    build,
    output logic [8:0]              build_line
);

    logic access;
    logic in_table;
    logic hit_cmd;
    logic hit_status;
    logic hit_bank;
    logic cmd_reject;
    logic done_sticky;

    assign access     = psel && penable;
    assign in_table   = !paddr[12];           // 0x000..0xffc, one word per address
    assign hit_cmd    = paddr == `APB_CMD;
    assign hit_status = paddr == `APB_STATUS;
    assign hit_bank   = paddr == `APB_BANK;
    assign cmd_reject = hit_cmd && (busy || build);  // build pulse counts as busy

    assign pready  = 1'b1;
    assign pslverr = access && (!(in_table || hit_cmd || hit_status || hit_bank) ||
                                (pwrite && cmd_reject));

    assign table_we    = access && pwrite && in_table;
    assign table_waddr = paddr[11:2];
    assign table_wdata = pwdata[15:0];

    always_comb begin
        prdata = 32'd0;                       // table window is write only
        if (hit_status) prdata = {30'd0, done_sticky, busy};
        if (hit_bank)   prdata = {24'd0, bank_mask, bank_offset};
        if (hit_cmd)    prdata = {23'd0, build_line};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            build       <= 1'b0;
            build_line  <= 9'd0;
            bank_offset <= 4'd0;
            bank_mask   <= 4'hf;
            done_sticky <= 1'b0;
        end else begin
            build <= access && pwrite && hit_cmd && !cmd_reject;
            if (access && pwrite && hit_cmd && !cmd_reject) build_line <= pwdata[8:0];
            if (access && pwrite && hit_bank) begin
                bank_offset <= pwdata[3:0];
                bank_mask   <= pwdata[7:4];
            end
            if (done) done_sticky <= 1'b1;    // a new done beats the read clear
            else if (access && !pwrite && hit_status) done_sticky <= 1'b0;
        end
    end

endmodule

// ==== obj_dpram.sv ====
`timescale 1ns/1ps

module obj_dpram #(
    parameter type payload_t = logic [15:0],
    parameter int  depth     = 1024
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== obj_line_pkg.sv ====
package obj_line_pkg;

    typedef logic [15:0] obj_word_t;   // attr, code, y or x word of the object table
    typedef logic [15:0] line_word_t;  // one word of a line buffer slot

    // scan states, the RD_* names follow the word on the table read port
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RD_ATTR,    // table read latency
        ST_RD_CODE,
        ST_RD_Y,
        ST_RD_X,
        ST_CHK_MAP,
        ST_CHK_VIS,
        ST_WR0,
        ST_WR1,
        ST_WR2,
        ST_ADV,
        ST_FILL0,
        ST_FILL1,
        ST_FILL2
    } fsm_state_t;

endpackage

// ==== obj_line_cfg.svh ====
`ifndef OBJ_LINE_CFG_SVH
`define OBJ_LINE_CFG_SVH

`define OBJ_TABLE_WORDS 1024  // 256 sprites x 4 words
`define LINE_SLOTS      128
`define LINE_WORDS      1024  // 2 banks x 128 slots x 4 words

// a tile only keeps its slot inside this x window
`define X_MIN           48
`define X_MAX           448

`define APB_CMD         13'h1000
`define APB_STATUS      13'h1004
`define APB_BANK        13'h1008

`endif
